// ==== tb.f ====
+incdir+include
logic/bridge_pkg.sv
logic/byte_fifo.sv
logic/cmd_parser.sv
logic/dev_regs.sv
logic/transfer_ctrl.sv
logic/bridge_top.sv
testbench/bridge_checker.sv
testbench/tb_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_top
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ps
`include "bridge_macros.svh"

module tb_top;

    localparam int                WAIT_LIMIT = 2000;
    localparam bridge_pkg::addr_t REG_BASE   = `BRIDGE_REG_BASE;

    logic              clk;
    logic              rst_n;
    logic              data_valid;
    bridge_pkg::byte_t data_in;
    logic              data_read;
    logic              input_full;
    bridge_pkg::byte_t data_out;
    logic              output_empty;
    logic              hold_out;

    // Reference copy of the memory and the register block
    bridge_pkg::byte_t ref_mem [0:`BRIDGE_MEM_SIZE-1];
    bridge_pkg::word_t ref_fb_addr;
    bridge_pkg::word_t ref_fb_config;
    bridge_pkg::byte_t wr_buf [$];

    bridge_top dut_i
    (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_data_valid   (data_valid),
        .i_data         (data_in),
        .i_data_read    (data_read),
        .o_input_full   (input_full),
        .o_data         (data_out),
        .o_output_empty (output_empty)
    );

    bridge_checker checker_i
    (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_empty (output_empty),
        .i_data  (data_out),
        .i_hold  (hold_out),
        .o_read  (data_read)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Byte k of a read; memory wraps on the low eight address bits
    function automatic bridge_pkg::byte_t ref_read_byte(input bridge_pkg::addr_t addr, input int k);
        bridge_pkg::word_t value;
        logic [7:0]        idx;
        if (addr >= REG_BASE)
        begin
            case (addr[11:2])
                10'd1:   value = ref_fb_addr;
                10'd2:   value = ref_fb_config;
                default: value = '0;
            endcase
            return value[8*k +: 8];
        end
        idx = 8'(addr + k);
        return ref_mem[idx];
    endfunction

    task abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task push_byte(input bridge_pkg::byte_t value);
        int waited;
        waited = 0;
        while (input_full)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("Input FIFO stayed full and a byte could not be sent");
        end
        data_valid = 1'b1;
        data_in    = value;
        @(negedge clk);
        data_valid = 1'b0;
    endtask

    task send_cmd(input bridge_pkg::byte_t op, input bridge_pkg::addr_t addr,
                  input bridge_pkg::size_t size);
        int i;
        push_byte(op);
        for (i = 0; i < 4; i++)
            push_byte(addr[8*i +: 8]);
        for (i = 0; i < 4; i++)
            push_byte(size[8*i +: 8]);
    endtask

    task fill_buf(input int n);
        wr_buf.delete();
        repeat (n) wr_buf.push_back(8'($urandom()));
    endtask

    task mem_write(input bridge_pkg::addr_t addr, input int max_gap);
        int i;
        int gap;
        send_cmd(`BRIDGE_OP_WRITE, addr, bridge_pkg::size_t'(wr_buf.size()));
        for (i = 0; i < wr_buf.size(); i++)
        begin
            gap = $urandom_range(max_gap, 0);
            repeat (gap) @(negedge clk);
            push_byte(wr_buf[i]);
            ref_mem[8'(addr + i)] = wr_buf[i];
        end
    endtask

    task read_cmd(input bridge_pkg::addr_t addr, input bridge_pkg::size_t size);
        int count;
        int k;
        count = (addr >= REG_BASE) ? 4 : ((size == 0) ? 1 : int'(size));
        for (k = 0; k < count; k++)
            checker_i.expect_byte(ref_read_byte(addr, k));
        send_cmd(`BRIDGE_OP_READ, addr, size);
    endtask

    task reg_write(input int idx, input bridge_pkg::word_t value);
        send_cmd(`BRIDGE_OP_WRITE, REG_BASE + 32'(idx * 4), value);
        if (idx == 1)
            ref_fb_addr = value;
        else if (idx == 2)
            ref_fb_config = value;
    endtask

    task load_reg_defaults();
        ref_fb_addr   = `BRIDGE_FB_ADDR_RST;
        ref_fb_config = `BRIDGE_FB_CONFIG_RST;
    endtask

    task finish_test();
        int waited;
        waited = 0;
        while (checker_i.pending() != 0)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("Expected output bytes never arrived from the output FIFO");
        end
        // Quiet window so stray bytes count against this test
        repeat (10) @(negedge clk);
        checker_i.report_test();
    endtask

    initial
    begin
        void'($urandom(32'ha78b_e7a4));
        rst_n      = 1'b0;
        data_valid = 1'b0;
        data_in    = '0;
        hold_out   = 1'b0;
        load_reg_defaults();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        checker_i.begin_test("reset_flags");
        checker_i.check_flag("o_input_full", 1'b0, input_full);
        checker_i.check_flag("o_output_empty", 1'b1, output_empty);
        checker_i.report_test();

        checker_i.begin_test("write_read_8");
        fill_buf(8);
        mem_write(32'h10, 0);
        read_cmd(32'h10, 32'd8);
        finish_test();

        checker_i.begin_test("reg_defaults");
        read_cmd(REG_BASE + 32'h4, 32'd4);
        read_cmd(REG_BASE + 32'h8, 32'd4);
        read_cmd(REG_BASE + 32'h20, 32'd4);
        finish_test();

        checker_i.begin_test("reg_write_reset");
        reg_write(1, $urandom());
        read_cmd(REG_BASE + 32'h4, 32'd4);
        send_cmd(`BRIDGE_OP_RESET, '0, '0);
        load_reg_defaults();
        read_cmd(REG_BASE + 32'h4, 32'd4);
        finish_test();

        checker_i.begin_test("input_stall_40");
        fill_buf(40);
        mem_write(32'h40, 6);
        read_cmd(32'h40, 32'd40);
        finish_test();

        checker_i.begin_test("output_backpressure_40");
        hold_out = 1'b1;
        read_cmd(32'h40, 32'd40);
        // Nine command and seven data bytes queue behind the stalled read
        fill_buf(7);
        mem_write(32'h80, 0);
        checker_i.check_flag("o_input_full", 1'b1, input_full);
        repeat ($urandom_range(80, 40)) @(negedge clk);
        hold_out = 1'b0;
        read_cmd(32'h80, 32'd7);
        finish_test();

        checker_i.begin_test("wrap_at_end");
        fill_buf(4);
        mem_write(32'hFE, 0);
        read_cmd(32'hFE, 32'd4);
        read_cmd(32'h00, 32'd2);
        finish_test();

        checker_i.begin_test("zero_size_read");
        read_cmd(32'h10, 32'd0);
        finish_test();

        checker_i.begin_test("unknown_opcode");
        send_cmd(8'h07, 32'h10, 32'd4);
        read_cmd(32'h11, 32'd2);
        finish_test();

        $display("Tests passed: %0d, failed: %0d, byte errors: %0d",
                 checker_i.pass_cnt, checker_i.fail_cnt, checker_i.error_cnt);
        if (checker_i.fail_cnt == 0 && checker_i.error_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== testbench/bridge_checker.sv ====
`timescale 1ns/1ps

module bridge_checker
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_empty,
    input  bridge_pkg::byte_t i_data,
    input  logic              i_hold,
    output logic              o_read
);

    bridge_pkg::byte_t exp_q [$];
    string             test_name = "none";
    int                seen_cnt  = 0;
    int                test_errs = 0;
    int                error_cnt = 0;
    int                pass_cnt  = 0;
    int                fail_cnt  = 0;
    logic              hold_q    = 1'b0;

    initial
    begin
        o_read = 1'b0;
    end

    function int pending();
        return exp_q.size();
    endfunction

    task begin_test(input string name);
        test_name = name;
        test_errs = 0;
        seen_cnt  = 0;
    endtask

    task expect_byte(input bridge_pkg::byte_t value);
        exp_q.push_back(value);
    endtask

    task check_flag(input string flag, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s %s expected %0b actual %0b",
                     test_name, flag, expected, actual);
            test_errs++;
        end
    endtask

    task check_byte(input bridge_pkg::byte_t actual);
        bridge_pkg::byte_t expected;
        if (exp_q.size() == 0)
        begin
            $display("%s: output byte 0x%02h arrived when no byte was expected",
                     test_name, actual);
            test_errs++;
        end
        else
        begin
            expected = exp_q.pop_front();
            if (actual !== expected)
            begin
                $display("[ERROR] %s byte %0d expected 0x%02h actual 0x%02h",
                         test_name, seen_cnt, expected, actual);
                test_errs++;
            end
        end
        seen_cnt++;
    endtask

    task report_test();
        if (test_errs == 0)
        begin
            pass_cnt++;
            $display("PASS  %s (%0d bytes)", test_name, seen_cnt);
        end
        else
        begin
            fail_cnt++;
            $display("FAIL  %s (%0d errors)", test_name, test_errs);
        end
        error_cnt += test_errs;
    endtask

    always @(posedge i_clk)
        hold_q <= i_hold;

    // The head byte is compared on the same edge that requests its pop
    always @(negedge i_clk)
    begin
        if (!i_rst_n || i_empty || hold_q)
            o_read <= 1'b0;
        else
        begin
            o_read <= 1'b1;
            check_byte(i_data);
        end
    end

endmodule

// ==== logic/bridge_top.sv ====
`timescale 1ns/1ps

module bridge_top
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_data_valid,
    input  bridge_pkg::byte_t i_data,
    input  logic              i_data_read,
    output logic              o_input_full,
    output bridge_pkg::byte_t o_data,
    output logic              o_output_empty
);

    logic                 in_empty;
    logic                 in_pop;
    logic                 parser_pop;
    logic                 ctrl_pop;
    bridge_pkg::byte_t    in_data;
    logic                 out_full;
    logic                 out_push;
    bridge_pkg::byte_t    out_data;
    logic                 cmd_valid;
    logic                 clear_cmd;
    bridge_pkg::byte_t    cmd_op;
    bridge_pkg::addr_t    cmd_addr;
    bridge_pkg::size_t    cmd_size;
    logic                 reg_soft_rst;
    logic                 reg_wr_en;
    bridge_pkg::reg_idx_t reg_idx;
    bridge_pkg::word_t    reg_wr_data;
    bridge_pkg::word_t    reg_rd_data;

    // Parser and controller never request a pop in the same cycle
    assign in_pop = parser_pop | ctrl_pop;

    byte_fifo in_fifo_i
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_write (i_data_valid),
        .i_data  (i_data),
        .i_read  (in_pop),
        .o_data  (in_data),
        .o_full  (o_input_full),
        .o_empty (in_empty)
    );

    byte_fifo out_fifo_i
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_write (out_push),
        .i_data  (out_data),
        .i_read  (i_data_read),
        .o_data  (o_data),
        .o_full  (out_full),
        .o_empty (o_output_empty)
    );

    cmd_parser parser_i
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_empty     (in_empty),
        .i_data      (in_data),
        .i_clear_cmd (clear_cmd),
        .o_pop       (parser_pop),
        .o_cmd_valid (cmd_valid),
        .o_cmd_op    (cmd_op),
        .o_cmd_addr  (cmd_addr),
        .o_cmd_size  (cmd_size)
    );

    transfer_ctrl ctrl_i
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_cmd_valid    (cmd_valid),
        .i_cmd_op       (cmd_op),
        .i_cmd_addr     (cmd_addr),
        .i_cmd_size     (cmd_size),
        .i_in_empty     (in_empty),
        .i_in_data      (in_data),
        .i_out_full     (out_full),
        .i_reg_rd_data  (reg_rd_data),
        .o_clear_cmd    (clear_cmd),
        .o_in_pop       (ctrl_pop),
        .o_out_push     (out_push),
        .o_out_data     (out_data),
        .o_reg_soft_rst (reg_soft_rst),
        .o_reg_wr_en    (reg_wr_en),
        .o_reg_idx      (reg_idx),
        .o_reg_wr_data  (reg_wr_data)
    );

    dev_regs regs_i
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_soft_rst (reg_soft_rst),
        .i_wr_en    (reg_wr_en),
        .i_wr_idx   (reg_idx),
        .i_wr_data  (reg_wr_data),
        .i_rd_idx   (reg_idx),
        .o_rd_data  (reg_rd_data)
    );

endmodule

// ==== logic/transfer_ctrl.sv ====
`timescale 1ns/1ps
`include "bridge_macros.svh"

module transfer_ctrl
(
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_cmd_valid,
    input  bridge_pkg::byte_t    i_cmd_op,
    input  bridge_pkg::addr_t    i_cmd_addr,
    input  bridge_pkg::size_t    i_cmd_size,
    input  logic                 i_in_empty,
    input  bridge_pkg::byte_t    i_in_data,
    input  logic                 i_out_full,
    input  bridge_pkg::word_t    i_reg_rd_data,
    output logic                 o_clear_cmd,
    output logic                 o_in_pop,
    output logic                 o_out_push,
    output bridge_pkg::byte_t    o_out_data,
    output logic                 o_reg_soft_rst,
    output logic                 o_reg_wr_en,
    output bridge_pkg::reg_idx_t o_reg_idx,
    output bridge_pkg::word_t    o_reg_wr_data
);

    bridge_pkg::xfer_state_t state;
    bridge_pkg::byte_t       mem [0:`BRIDGE_MEM_SIZE-1];
    bridge_pkg::addr_t       cur_addr;
    bridge_pkg::addr_t       end_addr;
    bridge_pkg::mem_addr_t   mem_idx;
    bridge_pkg::word_t       reg_shift;
    logic [1:0]              out_cnt;
    logic                    is_reg;
    logic                    last_addr;
    logic                    cmd_start;
    logic                    op_known;

    // Zero size still moves a single byte
    assign end_addr  = (i_cmd_size == '0) ? i_cmd_addr : i_cmd_addr + i_cmd_size - 1'b1;
    assign is_reg    = (i_cmd_addr >= `BRIDGE_REG_BASE);
    assign last_addr = (cur_addr == end_addr);
    assign mem_idx   = cur_addr[$bits(bridge_pkg::mem_addr_t)-1:0];
    assign cmd_start = (state == bridge_pkg::xfer_idle) && i_cmd_valid;
    assign op_known  = (i_cmd_op == `BRIDGE_OP_RESET) || (i_cmd_op == `BRIDGE_OP_READ)
                    || (i_cmd_op == `BRIDGE_OP_WRITE);

    assign o_in_pop   = (state == bridge_pkg::xfer_write) && !i_in_empty;
    assign o_out_push = ((state == bridge_pkg::xfer_read) || (state == bridge_pkg::xfer_reg_out))
                     && !i_out_full;
    assign o_out_data = (state == bridge_pkg::xfer_reg_out) ? reg_shift[7:0] : mem[mem_idx];

    assign o_reg_soft_rst = (state == bridge_pkg::xfer_reset);
    assign o_reg_idx      = i_cmd_addr[11:2];
    assign o_reg_wr_data  = i_cmd_size;
    assign o_reg_wr_en    = cmd_start && (i_cmd_op == `BRIDGE_OP_WRITE) && is_reg;

    always_comb
    begin
        case (state)
            bridge_pkg::xfer_idle:    o_clear_cmd = cmd_start && (!op_known || o_reg_wr_en);
            bridge_pkg::xfer_reset:   o_clear_cmd = 1'b1;
            bridge_pkg::xfer_read:    o_clear_cmd = o_out_push && last_addr;
            bridge_pkg::xfer_write:   o_clear_cmd = o_in_pop && last_addr;
            bridge_pkg::xfer_reg_out: o_clear_cmd = o_out_push && (out_cnt == 2'd3);
            default:                  o_clear_cmd = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            state   <= bridge_pkg::xfer_idle;
            out_cnt <= '0;
        end
        else if (state == bridge_pkg::xfer_idle)
        begin
            out_cnt <= '0;
            if (cmd_start)
            begin
                case (i_cmd_op)
                    `BRIDGE_OP_RESET: state <= bridge_pkg::xfer_reset;
                    `BRIDGE_OP_READ:  state <= is_reg ? bridge_pkg::xfer_reg_out
                                                      : bridge_pkg::xfer_read;
                    `BRIDGE_OP_WRITE:
                    begin
                        if (!is_reg)
                            state <= bridge_pkg::xfer_write;
                    end
                    default:          ;
                endcase
            end
        end
        else
        begin
            if ((state == bridge_pkg::xfer_reg_out) && o_out_push)
                out_cnt <= out_cnt + 1'b1;
            if (o_clear_cmd)
                state <= bridge_pkg::xfer_idle;
        end
    end

    // Address counter and register read shifter
    always_ff @(posedge i_clk)
    begin
        if (cmd_start)
        begin
            cur_addr  <= i_cmd_addr;
            reg_shift <= i_reg_rd_data;
        end
        else
        begin
            if (o_in_pop || ((state == bridge_pkg::xfer_read) && o_out_push))
                cur_addr <= cur_addr + 1'b1;
            if ((state == bridge_pkg::xfer_reg_out) && o_out_push)
                reg_shift <= reg_shift >> 8;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_in_pop)
            mem[mem_idx] <= i_in_data;
    end

endmodule

// ==== logic/dev_regs.sv ====
`timescale 1ns/1ps
`include "bridge_macros.svh"

module dev_regs
(
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_soft_rst,
    input  logic                 i_wr_en,
    input  bridge_pkg::reg_idx_t i_wr_idx,
    input  bridge_pkg::word_t    i_wr_data,
    input  bridge_pkg::reg_idx_t i_rd_idx,
    output bridge_pkg::word_t    o_rd_data
);

    localparam bridge_pkg::reg_idx_t FB_ADDR_IDX   = 10'd1;
    localparam bridge_pkg::reg_idx_t FB_CONFIG_IDX = 10'd2;

    bridge_pkg::word_t fb_addr;
    bridge_pkg::word_t fb_config;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_soft_rst)
        begin
            fb_addr   <= `BRIDGE_FB_ADDR_RST;
            fb_config <= `BRIDGE_FB_CONFIG_RST;
        end
        else if (i_wr_en)
        begin
            if (i_wr_idx == FB_ADDR_IDX)
                fb_addr <= i_wr_data;
            if (i_wr_idx == FB_CONFIG_IDX)
                fb_config <= i_wr_data;
        end
    end

    always_comb
    begin
        case (i_rd_idx)
            FB_ADDR_IDX:   o_rd_data = fb_addr;
            FB_CONFIG_IDX: o_rd_data = fb_config;
            default:       o_rd_data = '0;
        endcase
    end

endmodule

// ==== logic/cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_empty,
    input  bridge_pkg::byte_t i_data,
    input  logic              i_clear_cmd,
    output logic              o_pop,
    output logic              o_cmd_valid,
    output bridge_pkg::byte_t o_cmd_op,
    output bridge_pkg::addr_t o_cmd_addr,
    output bridge_pkg::size_t o_cmd_size
);

    bridge_pkg::parse_state_t state;
    logic [1:0]               byte_cnt;

    // Stop pulling bytes once a full command is held
    assign o_pop       = !i_empty && (state != bridge_pkg::parse_ready);
    assign o_cmd_valid = (state == bridge_pkg::parse_ready);

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            state    <= bridge_pkg::parse_opcode;
            byte_cnt <= '0;
        end
        else
        begin
            case (state)
                bridge_pkg::parse_opcode:
                begin
                    if (o_pop)
                        state <= bridge_pkg::parse_addr;
                end
                bridge_pkg::parse_addr:
                begin
                    if (o_pop)
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3)
                            state <= bridge_pkg::parse_size;
                    end
                end
                bridge_pkg::parse_size:
                begin
                    if (o_pop)
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3)
                            state <= bridge_pkg::parse_ready;
                    end
                end
                default:
                begin
                    if (i_clear_cmd)
                        state <= bridge_pkg::parse_opcode;
                end
            endcase
        end
    end

    // Fields fill least significant byte first
    always_ff @(posedge i_clk)
    begin
        if (o_pop)
        begin
            case (state)
                bridge_pkg::parse_opcode: o_cmd_op   <= i_data;
                bridge_pkg::parse_addr:   o_cmd_addr <= {i_data, o_cmd_addr[31:8]};
                bridge_pkg::parse_size:   o_cmd_size <= {i_data, o_cmd_size[31:8]};
                default:                  ;
            endcase
        end
    end

endmodule

// ==== logic/byte_fifo.sv ====
`timescale 1ns/1ps
`include "bridge_macros.svh"

module byte_fifo
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_write,
    input  bridge_pkg::byte_t i_data,
    input  logic              i_read,
    output bridge_pkg::byte_t o_data,
    output logic              o_full,
    output logic              o_empty
);

    localparam int PTR_W = $clog2(`BRIDGE_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`BRIDGE_FIFO_DEPTH + 1);

    bridge_pkg::byte_t buffer [0:`BRIDGE_FIFO_DEPTH-1];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              wr_en;
    logic              rd_en;

    assign o_full  = (count == CNT_W'(`BRIDGE_FIFO_DEPTH));
    assign o_empty = (count == '0);
    assign wr_en   = i_write && !o_full;
    assign rd_en   = i_read && !o_empty;

    // Head entry is always visible
    assign o_data = buffer[rd_ptr];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (wr_en)
            buffer[wr_ptr] <= i_data;
    end

endmodule

// ==== logic/bridge_pkg.sv ====
`include "bridge_macros.svh"

package bridge_pkg;

    typedef logic [`BRIDGE_DATA_W-1:0]           byte_t;
    typedef logic [31:0]                         addr_t;
    typedef logic [31:0]                         size_t;
    typedef logic [31:0]                         word_t;
    typedef logic [$clog2(`BRIDGE_MEM_SIZE)-1:0] mem_addr_t;
    typedef logic [9:0]                          reg_idx_t;

    typedef enum logic [1:0]
    {
        parse_opcode,
        parse_addr,
        parse_size,
        parse_ready
    } parse_state_t;

    typedef enum logic [2:0]
    {
        xfer_idle,
        xfer_reset,
        xfer_read,
        xfer_write,
        xfer_reg_out
    } xfer_state_t;

endpackage

// ==== include/bridge_macros.svh ====
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

`define BRIDGE_DATA_W        8
`define BRIDGE_FIFO_DEPTH    16
`define BRIDGE_MEM_SIZE      256

// Host addresses from here up map onto the register block
`define BRIDGE_REG_BASE      32'h3FFF_F000

`define BRIDGE_FB_ADDR_RST   32'h000C_0000
`define BRIDGE_FB_CONFIG_RST 32'h0000_003F

// Opcode byte at the head of each command
`define BRIDGE_OP_RESET      8'h00
`define BRIDGE_OP_READ       8'h01
`define BRIDGE_OP_WRITE      8'h02

`endif
